//--- include/i2sTx_settings.svh
`ifndef I2STX_SETTINGS_SVH
`define I2STX_SETTINGS_SVH

// ********************
// Bus and sample sizes
// ********************

`define I2STX_WB_DW       32   // Wishbone data width
`define I2STX_SAMPLE_W    24   // Audio sample width per channel
`define I2STX_SLOT_W      32   // Bit clocks in one channel slot

// ********************
// FIFO
// ********************

`define I2STX_FIFO_DEPTH  8    // Stereo frames held ahead of the serializer

// ********************
// Register word addresses
// ********************

`define I2STX_ADDR_CTRL   2'd0
`define I2STX_ADDR_STATUS 2'd1
`define I2STX_ADDR_LEFT   2'd2
`define I2STX_ADDR_RIGHT  2'd3

`endif

//--- src/i2sPkg.sv
`include "i2sTx_settings.svh"

package i2sPkg;

    // ********************
    // Audio data
    // ********************

    typedef struct packed {
        logic [`I2STX_SAMPLE_W-1:0] left;
        logic [`I2STX_SAMPLE_W-1:0] right;
    } stereoFrame_t;

    // ********************
    // Register layouts
    // ********************

    typedef struct packed {
        logic [7:0] clkDiv;    // Bits 8:1 of CTRL
        logic       enable;    // Bit 0 of CTRL
    } i2sCtrl_t;

    typedef struct packed {
        logic [3:0] level;     // Frames waiting in the FIFO
        logic       full;
        logic       empty;
        logic       underrun;  // Sticky, write 1 to clear
    } i2sStatus_t;

    // ********************
    // Wishbone classic
    // ********************

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [1:0]              adr;
        logic [`I2STX_WB_DW-1:0] dat;
    } wbReq_t;

    typedef struct packed {
        logic                    ack;
        logic [`I2STX_WB_DW-1:0] dat;
    } wbRsp_t;

    typedef enum logic [1:0] {
        IDLE,
        LEFT_SLOT,
        RIGHT_SLOT
    } serState_t;

endpackage

//--- src/i2sRegs.sv
`timescale 1ns/100ps
`include "i2sTx_settings.svh"

module i2sRegs (
    input  logic                 i_rstN,
    input  logic                 w_SCLK,
    input  i2sPkg::wbReq_t       i_wbReq,
    output i2sPkg::wbRsp_t       o_wbRsp,
    input  i2sPkg::i2sStatus_t   i_fifoStatus,
    input  logic                 i_underrun,
    output i2sPkg::i2sCtrl_t     o_ctrl,
    output logic                 o_push,
    output i2sPkg::stereoFrame_t o_pushFrame
);

    localparam int DW = `I2STX_WB_DW;
    localparam int SW = `I2STX_SAMPLE_W;
    localparam int CW = $bits(i2sPkg::i2sCtrl_t);

    logic               ack;
    logic [DW-1:0]      rdData;
    logic [DW-1:0]      rdNext;
    logic [SW-1:0]      leftStage;
    logic               stickyUnderrun;
    logic               busReq;
    logic               wrRight;
    logic               canAck;
    i2sPkg::i2sStatus_t statusRd;

    // ********************
    // Bus decode
    // ********************

    assign busReq  = i_wbReq.cyc && i_wbReq.stb && !ack;      // Ack pulse blocks a repeat
    assign wrRight = i_wbReq.we && (i_wbReq.adr == `I2STX_ADDR_RIGHT);
    assign canAck  = busReq && !(wrRight && i_fifoStatus.full); // Stall RIGHT while full

    assign statusRd = '{
        level:    i_fifoStatus.level,
        full:     i_fifoStatus.full,
        empty:    i_fifoStatus.empty,
        underrun: stickyUnderrun
    };

    always_comb begin
        case (i_wbReq.adr)
            `I2STX_ADDR_CTRL:   rdNext = DW'(o_ctrl);
            `I2STX_ADDR_STATUS: rdNext = DW'(statusRd);
            `I2STX_ADDR_LEFT:   rdNext = DW'(leftStage);
            default:            rdNext = '0;  // RIGHT is write only
        endcase
    end

    // ********************
    // Control state
    // ********************

    always_ff @(posedge w_SCLK) begin
        if (!i_rstN) begin
            ack            <= 1'b0;
            o_push         <= 1'b0;
            o_ctrl         <= '0;
            stickyUnderrun <= 1'b0;
        end else begin
            ack    <= canAck;
            o_push <= canAck && wrRight;  // Push lands with the ack

            if (canAck && i_wbReq.we && (i_wbReq.adr == `I2STX_ADDR_CTRL)) begin
                o_ctrl <= i2sPkg::i2sCtrl_t'(i_wbReq.dat[CW-1:0]);
            end

            if (i_underrun) begin
                stickyUnderrun <= 1'b1;  // A new event wins over a clear
            end else if (canAck && i_wbReq.we && (i_wbReq.adr == `I2STX_ADDR_STATUS)
                         && i_wbReq.dat[0]) begin
                stickyUnderrun <= 1'b0;
            end
        end
    end

    // ********************
    // Data registers
    // ********************

    always_ff @(posedge w_SCLK) begin
        if (canAck && i_wbReq.we && (i_wbReq.adr == `I2STX_ADDR_LEFT)) begin
            leftStage <= i_wbReq.dat[SW-1:0];
        end
        if (canAck && wrRight) begin
            o_pushFrame <= '{left: leftStage, right: i_wbReq.dat[SW-1:0]};
        end
        if (canAck && !i_wbReq.we) begin
            rdData <= rdNext;
        end
    end

    assign o_wbRsp = '{ack: ack, dat: rdData};

endmodule

//--- src/sampleFifo.sv
`timescale 1ns/100ps
`include "i2sTx_settings.svh"

module sampleFifo #(
    parameter int DEPTH = `I2STX_FIFO_DEPTH
) (
    input  logic                 i_rstN,
    input  logic                 w_SCLK,
    input  logic                 i_push,
    input  i2sPkg::stereoFrame_t i_pushFrame,
    input  logic                 i_pop,
    output i2sPkg::stereoFrame_t o_popFrame,
    output i2sPkg::i2sStatus_t   o_status
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [3:0] FULL_LEVEL = 4'(DEPTH);

    i2sPkg::stereoFrame_t mem [DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [3:0]       level;
    logic             full;
    logic             empty;
    logic             doPush;
    logic             doPop;

    assign full   = (level == FULL_LEVEL);
    assign empty  = (level == 4'd0);
    assign doPush = i_push && !full;   // Extra pushes are dropped
    assign doPop  = i_pop && !empty;

    // ********************
    // Pointers and level
    // ********************

    always_ff @(posedge w_SCLK) begin
        if (!i_rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == LAST_PTR) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == LAST_PTR) ? '0 : rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   level <= level + 4'd1;
                2'b01:   level <= level - 4'd1;
                default: level <= level;  // Push with pop keeps the level
            endcase
        end
    end

    always_ff @(posedge w_SCLK) begin
        if (doPush) begin
            mem[wrPtr] <= i_pushFrame;
        end
    end

    assign o_popFrame = mem[rdPtr];  // Head frame shows without a pop

    assign o_status = '{level: level, full: full, empty: empty, underrun: 1'b0};

endmodule

//--- src/bitClockGen.sv
`timescale 1ns/100ps

module bitClockGen (
    input  logic             i_rstN,
    input  logic             w_SCLK,
    input  i2sPkg::i2sCtrl_t i_ctrl,
    output logic             o_bclk,
    output logic             o_bclkRise,
    output logic             o_bclkFall
);

    logic [7:0] divCnt;
    logic       toggle;

    // ********************
    // Edge strobes
    // ********************

    // The strobe is high in the cycle whose clock edge flips the level
    assign toggle     = i_ctrl.enable && (divCnt == 8'd0);
    assign o_bclkRise = toggle && !o_bclk;
    assign o_bclkFall = toggle && o_bclk;

    // ********************
    // Divider
    // ********************

    always_ff @(posedge w_SCLK) begin
        if (!i_rstN || !i_ctrl.enable) begin
            divCnt <= 8'd0;  // First toggle comes right after enable
            o_bclk <= 1'b0;
        end else if (toggle) begin
            divCnt <= i_ctrl.clkDiv;  // Half period is clkDiv+1 clocks
            o_bclk <= !o_bclk;
        end else begin
            divCnt <= divCnt - 8'd1;
        end
    end

endmodule

//--- src/i2sSerializer.sv
`timescale 1ns/100ps
`include "i2sTx_settings.svh"

module i2sSerializer (
    input  logic                 i_rstN,
    input  logic                 w_SCLK,
    input  logic                 i_enable,
    input  logic                 i_bclkFall,
    input  logic                 i_fifoEmpty,
    input  i2sPkg::stereoFrame_t i_frame,
    output logic                 o_pop,
    output logic                 o_underrun,
    output logic                 o_lrck,
    output logic                 o_sdata
);

    localparam int SW = `I2STX_SAMPLE_W;
    localparam logic [4:0] LAST_BIT = 5'(`I2STX_SLOT_W - 1);

    i2sPkg::serState_t state;

    logic [4:0]    bitCnt;
    logic [SW-1:0] shiftReg;
    logic [SW-1:0] rightHold;
    logic          slotEnd;
    logic          leftStart;

    assign slotEnd   = (bitCnt == LAST_BIT);
    assign leftStart = i_enable && i_bclkFall &&
                       ((state == i2sPkg::IDLE) ||
                        ((state == i2sPkg::RIGHT_SLOT) && slotEnd));

    assign o_pop      = leftStart && !i_fifoEmpty;
    assign o_underrun = leftStart && i_fifoEmpty;  // Silence goes out instead

    // ********************
    // Slot FSM
    // ********************

    always_ff @(posedge w_SCLK) begin
        if (!i_rstN || !i_enable) begin
            state   <= i2sPkg::IDLE;
            bitCnt  <= 5'd0;
            o_lrck  <= 1'b0;
            o_sdata <= 1'b0;
        end else if (i_bclkFall) begin
            case (state)
                i2sPkg::IDLE: begin
                    state   <= i2sPkg::LEFT_SLOT;
                    bitCnt  <= 5'd0;
                    o_lrck  <= 1'b0;
                    o_sdata <= 1'b0;
                end
                i2sPkg::LEFT_SLOT: begin
                    bitCnt <= bitCnt + 5'd1;  // Wraps to zero at slot end
                    if (slotEnd) begin
                        state   <= i2sPkg::RIGHT_SLOT;
                        o_lrck  <= 1'b1;
                        o_sdata <= 1'b0;  // Last padding bit of the left slot
                    end else begin
                        o_sdata <= shiftReg[SW-1];
                    end
                end
                i2sPkg::RIGHT_SLOT: begin
                    bitCnt <= bitCnt + 5'd1;
                    if (slotEnd) begin
                        state   <= i2sPkg::LEFT_SLOT;
                        o_lrck  <= 1'b0;
                        o_sdata <= 1'b0;  // Frame's final bit spills into the next left slot
                    end else begin
                        o_sdata <= shiftReg[SW-1];
                    end
                end
                default: state <= i2sPkg::IDLE;
            endcase
        end
    end

    // ********************
    // Sample shifter
    // ********************

    always_ff @(posedge w_SCLK) begin
        if (leftStart) begin
            shiftReg  <= i_fifoEmpty ? '0 : i_frame.left;
            rightHold <= i_fifoEmpty ? '0 : i_frame.right;
        end else if (i_bclkFall && (state == i2sPkg::LEFT_SLOT) && slotEnd) begin
            shiftReg <= rightHold;
        end else if (i_bclkFall) begin
            shiftReg <= shiftReg << 1;  // Zeros fill the rest of the slot
        end
    end

endmodule

//--- src/i2sTxTop.sv
`timescale 1ns/100ps

module i2sTxTop (
    input  logic           i_rstN,
    input  logic           w_SCLK,
    input  i2sPkg::wbReq_t i_wbReq,
    output i2sPkg::wbRsp_t o_wbRsp,
    output logic           o_bclk,
    output logic           o_lrck,
    output logic           o_sdata
);

    i2sPkg::i2sCtrl_t     ctrl;
    i2sPkg::i2sStatus_t   fifoStatus;
    i2sPkg::stereoFrame_t pushFrame;
    i2sPkg::stereoFrame_t popFrame;

    logic push;
    logic pop;
    logic underrun;
    logic bclkFall;

    // ********************
    // Register block
    // ********************

    i2sRegs u_regs (
        .i_rstN       (i_rstN),
        .w_SCLK       (w_SCLK),
        .i_wbReq      (i_wbReq),
        .o_wbRsp      (o_wbRsp),
        .i_fifoStatus (fifoStatus),
        .i_underrun   (underrun),
        .o_ctrl       (ctrl),
        .o_push       (push),
        .o_pushFrame  (pushFrame)
    );

    // ********************
    // Datapath
    // ********************

    sampleFifo u_fifo (
        .i_rstN      (i_rstN),
        .w_SCLK      (w_SCLK),
        .i_push      (push),
        .i_pushFrame (pushFrame),
        .i_pop       (pop),
        .o_popFrame  (popFrame),
        .o_status    (fifoStatus)
    );

    bitClockGen u_bclkGen (
        .i_rstN     (i_rstN),
        .w_SCLK     (w_SCLK),
        .i_ctrl     (ctrl),
        .o_bclk     (o_bclk),
        .o_bclkRise (),
        .o_bclkFall (bclkFall)
    );

    i2sSerializer u_ser (
        .i_rstN      (i_rstN),
        .w_SCLK      (w_SCLK),
        .i_enable    (ctrl.enable),
        .i_bclkFall  (bclkFall),
        .i_fifoEmpty (fifoStatus.empty),
        .i_frame     (popFrame),
        .o_pop       (pop),
        .o_underrun  (underrun),
        .o_lrck      (o_lrck),
        .o_sdata     (o_sdata)
    );

endmodule

//--- dv/i2sTx_sva.sv
`timescale 1ns/100ps

module i2sTxSva (
    input logic           w_SCLK,
    input logic           i_rstN,
    input i2sPkg::wbRsp_t i_wbRsp,
    input logic           i_enable,
    input logic           i_bclkFall,
    input logic           i_lrck,
    input logic           i_sdata
);

    int errCount = 0;  // Read by the testbench at the end of the run

    // ********************
    // Bus rules
    // ********************

    ackOnePulse: assert property (@(posedge w_SCLK) disable iff (!i_rstN)
        i_wbRsp.ack |=> !i_wbRsp.ack)
        else begin
            errCount++;
            $error("Wishbone ack was high for two cycles in a row");
        end

    // ********************
    // Serial rules
    // ********************

    // Clearing enable drops both lines at once, without a strobe
    sdataOnFall: assert property (@(posedge w_SCLK) disable iff (!i_rstN)
        !$stable(i_sdata) |-> $past(i_bclkFall) || !$past(i_enable))
        else begin
            errCount++;
            $error("o_sdata changed without a bit clock fall strobe");
        end

    lrckOnFall: assert property (@(posedge w_SCLK) disable iff (!i_rstN)
        !$stable(i_lrck) |-> $past(i_bclkFall) || !$past(i_enable))
        else begin
            errCount++;
            $error("o_lrck changed without a bit clock fall strobe");
        end

endmodule

bind i2sTxTop i2sTxSva u_sva (
    .w_SCLK     (w_SCLK),
    .i_rstN     (i_rstN),
    .i_wbRsp    (o_wbRsp),
    .i_enable   (ctrl.enable),
    .i_bclkFall (bclkFall),
    .i_lrck     (o_lrck),
    .i_sdata    (o_sdata)
);

//--- dv/i2sTxTb.sv
`timescale 1ns/100ps
`include "i2sTx_settings.svh"

module i2sTxTb;

    localparam int SW          = `I2STX_SAMPLE_W;
    localparam int STW         = $bits(i2sPkg::i2sStatus_t);
    localparam int CW          = $bits(i2sPkg::i2sCtrl_t);
    localparam int ACK_LIMIT   = 1000;
    localparam int DRAIN_LIMIT = 40000;
    localparam int EVENT_LIMIT = 5000;

    logic                 w_SCLK;
    logic                 rstN;
    i2sPkg::wbReq_t       wbReq;
    i2sPkg::wbRsp_t       wbRsp;
    logic                 bclk;
    logic                 lrck;
    logic                 sdata;

    i2sPkg::stereoFrame_t expQ[$];
    i2sPkg::stereoFrame_t rxQ[$];
    i2sPkg::i2sCtrl_t     ctrlShadow;
    string                testName;
    int                   seed;
    int                   mismatchCount;
    int                   failCount;
    int                   rxCount;
    int                   lastWait;
    int                   bitIdx;
    logic                 prevLrck;
    logic                 prevBclk;
    logic [SW-1:0]        leftAcc;
    logic [SW-1:0]        rightAcc;

    i2sTxTop u_dut (
        .i_rstN  (rstN),
        .w_SCLK  (w_SCLK),
        .i_wbReq (wbReq),
        .o_wbRsp (wbRsp),
        .o_bclk  (bclk),
        .o_lrck  (lrck),
        .o_sdata (sdata)
    );

    initial w_SCLK = 1'b0;
    always #4 w_SCLK = !w_SCLK;

    // ********************
    // Reference and checks
    // ********************

    function automatic i2sPkg::stereoFrame_t expectedFrame(input logic [31:0] leftWord,
                                                           input logic [31:0] rightWord);
        i2sPkg::stereoFrame_t frame;
        frame.left  = leftWord[SW-1:0];   // Upper byte of each bus word is dropped
        frame.right = rightWord[SW-1:0];
        return frame;
    endfunction

    task automatic checkFrame(input string name, input i2sPkg::stereoFrame_t exp,
                              input i2sPkg::stereoFrame_t act);
        if (act !== exp) begin
            mismatchCount++;
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkCtrl(input string name, input i2sPkg::i2sCtrl_t exp,
                             input i2sPkg::i2sCtrl_t act);
        if (act !== exp) begin
            mismatchCount++;
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkStatus(input string name, input i2sPkg::i2sStatus_t exp,
                               input i2sPkg::i2sStatus_t act);
        if (act !== exp) begin
            mismatchCount++;
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        if (act != exp) begin
            mismatchCount++;
            $display("Mismatch %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic finishRun();
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatchCount, failCount, u_dut.u_sva.errCount);
        if (mismatchCount + failCount + u_dut.u_sva.errCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    task automatic timedOut(input string what);
        failCount++;
        $display("Timed out waiting for %s in test %s", what, testName);
        finishRun();
    endtask

    // ********************
    // Wishbone master
    // ********************

    task automatic waitAck();
        logic gotAck;
        gotAck   = 1'b0;
        lastWait = 0;
        while (!gotAck && lastWait < ACK_LIMIT) begin
            @(posedge w_SCLK);
            #1;
            lastWait++;
            gotAck = wbRsp.ack;
        end
        if (!gotAck) begin
            timedOut("Wishbone ack");
        end
    endtask

    task automatic wbWrite(input logic [1:0] adr, input logic [31:0] dat);
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        waitAck();
        wbReq = '0;
    endtask

    task automatic wbRead(input logic [1:0] adr, output logic [31:0] dat);
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'd0};
        waitAck();
        dat   = wbRsp.dat;
        wbReq = '0;
    endtask

    task automatic writeCtrl(input i2sPkg::i2sCtrl_t ctrl);
        wbWrite(`I2STX_ADDR_CTRL, 32'(ctrl));
        if (ctrl.enable && !ctrlShadow.enable) begin
            bitIdx   = -2;    // Two rises pass before the first left MSB
            prevLrck = 1'b0;
        end
        ctrlShadow = ctrl;
    endtask

    task automatic ctrlRoundTrip(input i2sPkg::i2sCtrl_t ctrl);
        logic [31:0] rd;
        writeCtrl(ctrl);
        wbRead(`I2STX_ADDR_CTRL, rd);
        checkCtrl(testName, ctrl, i2sPkg::i2sCtrl_t'(rd[CW-1:0]));
    endtask

    task automatic expectStatus(input logic [3:0] level, input logic full, input logic empty,
                                input logic underrun);
        logic [31:0]        rd;
        i2sPkg::i2sStatus_t exp;
        exp = '{level: level, full: full, empty: empty, underrun: underrun};
        wbRead(`I2STX_ADDR_STATUS, rd);
        checkStatus(testName, exp, i2sPkg::i2sStatus_t'(rd[STW-1:0]));
    endtask

    task automatic writeFrame(input bit track);
        logic [31:0] leftWord;
        logic [31:0] rightWord;
        leftWord  = $random(seed);
        rightWord = $random(seed);
        wbWrite(`I2STX_ADDR_LEFT, leftWord);
        wbWrite(`I2STX_ADDR_RIGHT, rightWord);
        if (track) begin
            expQ.push_back(expectedFrame(leftWord, rightWord));
        end
    endtask

    // ********************
    // Waits
    // ********************

    task automatic waitDrained();
        int n;
        n = 0;
        while ((expQ.size() > 0 || rxQ.size() > 0) && n < DRAIN_LIMIT) begin
            @(posedge w_SCLK);
            #1;
            n++;
        end
        if (expQ.size() > 0 || rxQ.size() > 0) begin
            timedOut("all written frames to arrive");
        end
    endtask

    task automatic waitRxFrames(input int count);
        int n;
        int target;
        n      = 0;
        target = rxCount + count;
        while (rxCount < target && n < EVENT_LIMIT) begin
            @(posedge w_SCLK);
            #1;
            n++;
        end
        if (rxCount < target) begin
            timedOut("received frames");
        end
    endtask

    task automatic waitLrckFall();
        int   n;
        logic last;
        bit   seen;
        n    = 0;
        seen = 1'b0;
        last = lrck;
        while (!seen && n < EVENT_LIMIT) begin
            @(posedge w_SCLK);
            #1;
            n++;
            seen = last && !lrck;
            last = lrck;
        end
        if (!seen) begin
            timedOut("an o_lrck falling edge");
        end
    endtask

    task automatic waitRightDataRise();
        int   n;
        logic last;
        bit   seen;
        n    = 0;
        seen = 1'b0;
        last = sdata;
        while (!seen && n < EVENT_LIMIT) begin
            @(posedge w_SCLK);
            #1;
            n++;
            seen = lrck && sdata && !last;
            last = sdata;
        end
        if (!seen) begin
            timedOut("a high data bit in the right slot");
        end
    endtask

    task automatic measureBclk(input logic [7:0] div);
        int   n;
        int   rises;
        int   t2;
        int   t3;
        logic last;
        n     = 0;
        rises = 0;
        t2    = 0;
        t3    = 0;
        writeCtrl('{clkDiv: div, enable: 1'b1});
        last = bclk;
        while (rises < 3 && n < EVENT_LIMIT) begin
            @(posedge w_SCLK);
            #1;
            n++;
            if (bclk && !last) begin
                rises++;
                if (rises == 2) t2 = n;  // First rise may still run on the old divider
                if (rises == 3) t3 = n;
            end
            last = bclk;
        end
        if (rises < 3) begin
            timedOut("o_bclk rises");
        end
        checkCount(testName, 2 * (div + 1), t3 - t2);
    endtask

    task automatic checkQuiet(input int cycles);
        int n;
        bit quiet;
        quiet = 1'b1;
        @(posedge w_SCLK);  // Outputs clear one clock after enable drops
        #1;
        for (n = 0; n < cycles; n++) begin
            if (bclk || lrck || sdata) quiet = 1'b0;
            @(posedge w_SCLK);
            #1;
        end
        if (!quiet) begin
            failCount++;
            $display("Serial outputs went high while disabled in test %s", testName);
        end
    endtask

    // ********************
    // Serial monitor and compare
    // ********************

    always @(negedge w_SCLK) begin
        if (bclk && !prevBclk) begin
            if (lrck != prevLrck) bitIdx = 0;  // This bit still pads the previous slot
            else bitIdx = bitIdx + 1;
            if (bitIdx >= 1 && bitIdx <= SW) begin
                if (lrck) rightAcc = {rightAcc[SW-2:0], sdata};
                else leftAcc = {leftAcc[SW-2:0], sdata};
            end
            if (lrck && bitIdx == SW) begin
                rxQ.push_back('{left: leftAcc, right: rightAcc});
                rxCount++;
            end
            prevLrck = lrck;
        end
        prevBclk = bclk;
    end

    always @(posedge w_SCLK) begin : compareFrames
        i2sPkg::stereoFrame_t want;
        i2sPkg::stereoFrame_t got;
        if (rxQ.size() > 0) begin
            got = rxQ.pop_front();
            if (expQ.size() > 0) want = expQ.pop_front();
            else want = '0;  // Underrun frames go out as silence
            checkFrame(testName, want, got);
        end
    end

    // ********************
    // Test sequence
    // ********************

    initial begin
        seed          = 77;
        mismatchCount = 0;
        failCount     = 0;
        rxCount       = 0;
        lastWait      = 0;
        bitIdx        = -2;
        prevLrck      = 1'b0;
        prevBclk      = 1'b0;
        ctrlShadow    = '0;
        testName      = "reset";
        rstN          = 1'b0;
        wbReq         = '0;
        repeat (2) @(posedge w_SCLK);
        #1;
        rstN = 1'b1;

        testName = "regAccess";
        expectStatus(4'd0, 1'b0, 1'b1, 1'b0);
        ctrlRoundTrip('{clkDiv: 8'h5A, enable: 1'b0});
        ctrlRoundTrip('{clkDiv: 8'($random(seed)), enable: 1'b0});

        testName = "frameOrder";
        writeCtrl('{clkDiv: 8'd1, enable: 1'b0});
        repeat (3) writeFrame(1'b1);
        writeCtrl('{clkDiv: 8'd1, enable: 1'b1});
        repeat (7) writeFrame(1'b1);  // The last one waits for room in the FIFO
        waitDrained();

        testName = "bclkRate";
        measureBclk(8'd0);
        measureBclk(8'd3);

        testName = "underrun";
        waitRxFrames(2);
        expectStatus(4'd0, 1'b0, 1'b1, 1'b1);
        writeCtrl('{clkDiv: 8'd3, enable: 1'b0});
        wbWrite(`I2STX_ADDR_STATUS, 32'd1);
        expectStatus(4'd0, 1'b0, 1'b1, 1'b0);

        testName = "backPressure";
        writeCtrl('{clkDiv: 8'd15, enable: 1'b0});
        repeat (8) writeFrame(1'b1);
        expectStatus(4'd8, 1'b1, 1'b0, 1'b0);
        writeCtrl('{clkDiv: 8'd15, enable: 1'b1});
        writeFrame(1'b1);
        // A pop needs the bit clock to rise and then fall
        if (lastWait < 15) begin
            failCount++;
            $display("Ninth RIGHT write in test %s was acknowledged after %0d cycles",
                     testName, lastWait);
        end
        waitDrained();

        testName = "disable";
        waitLrckFall();
        wbWrite(`I2STX_ADDR_STATUS, 32'd1);
        repeat (4) writeFrame(1'b0);  // Only the first of these goes out before the disable
        waitLrckFall();
        expectStatus(4'd3, 1'b0, 1'b0, 1'b0);
        waitRightDataRise();  // Disable lands while o_lrck and o_sdata are both high
        writeCtrl('{clkDiv: 8'd15, enable: 1'b0});
        checkQuiet(300);
        expectStatus(4'd3, 1'b0, 1'b0, 1'b0);

        finishRun();
    end

endmodule

//--- tb.f
+incdir+include
src/i2sPkg.sv
src/i2sRegs.sv
src/sampleFifo.sv
src/bitClockGen.sv
src/i2sSerializer.sv
src/i2sTxTop.sv
dv/i2sTx_sva.sv
dv/i2sTxTb.sv
